/* flist.f */
src/exu_pkg.sv
src/exu_alu.sv
src/exu_csr_file.sv
src/exu_core.sv
src/exu_data_mem.sv
src/exu_top.sv
verification/exu_asserts.sv
verification/exu_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module exu_tb \
  -f flist.f -o exu_sim || exit 1
out=$(./obj_dir/exu_sim)
echo "$out"
echo "$out" | grep -qx "No errors" && exit 0 || exit 1

/* verification/exu_tb.sv */
`timescale 1ns/100ps

module exu_tb import exu_pkg::*; ();

  localparam int xlen      = 64;
  localparam int mem_words = 256;
  localparam int mem_delay = 3;

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic        in_ready_o;
  exu_issue_t  in_issue_i;
  logic        out_valid_o;
  logic        out_ready_i;
  exu_result_t out_result_o;

  integer seed = 32'h94c9_eed4;

  // stimulus table and expected records
  string       names[$];
  exu_issue_t  issues[$];
  exu_result_t expected[$];

  // reference model state
  logic [63:0] mem_model [int];
  logic [63:0] m_mstatus = '0;
  logic [63:0] m_mtvec = '0;
  logic [63:0] m_mepc = '0;
  logic [63:0] m_mcause = '0;
  logic [63:0] cur_pc = 64'h1000;

  int res_idx = 0;
  int mismatch_cnt = 0;
  int other_cnt = 0;
  int cycles = 0;
  int limit = 0;
  int stall_left = 0;

  exu_top #(
    .XLEN      (xlen),
    .MEM_WORDS (mem_words),
    .MEM_DELAY (mem_delay)
  ) dut_i (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_issue_i   (in_issue_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_result_o (out_result_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic logic [4:0] rand_rd();
    logic [31:0] r;
    r = $random(seed);
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  function automatic logic [63:0] alu_model(alu_op_e op, logic [63:0] a, logic [63:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_sll:  return a << sh;
      alu_srl:  return a >> sh;
      alu_sra:  return $signed(a) >>> sh;
      alu_slt:  return {63'd0, $signed(a) < $signed(b)};
      alu_sltu: return {63'd0, a < b};
      alu_sle:  return {63'd0, $signed(a) <= $signed(b)};
      alu_sleu: return {63'd0, a <= b};
      default:  return 64'd0;
    endcase
  endfunction

  // branch decision straight from the operands
  function automatic logic branch_taken(alu_op_e op, logic [63:0] a, logic [63:0] b);
    case (op)
      alu_sub:  return a == b;
      alu_xor:  return a != b;
      alu_slt:  return $signed(a) < $signed(b);
      alu_sltu: return a < b;
      alu_sle:  return $signed(a) <= $signed(b);
      alu_sleu: return a <= b;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic int word_index(logic [63:0] addr);
    return int'((addr >> 3) % 64'(mem_words));
  endfunction

  function automatic logic [63:0] csr_read(logic [11:0] num);
    case (num)
      csr_mstatus: return m_mstatus;
      csr_mtvec:   return m_mtvec;
      csr_mepc:    return m_mepc;
      csr_mcause:  return m_mcause;
      default:     return 64'd0;
    endcase
  endfunction

  function automatic void csr_write(logic [11:0] num, logic [63:0] val);
    case (num)
      csr_mstatus: m_mstatus = val;
      csr_mtvec:   m_mtvec = val;
      csr_mepc:    m_mepc = val;
      csr_mcause:  m_mcause = val;
      default:     m_mstatus = m_mstatus;
    endcase
  endfunction

  function automatic exu_issue_t make_issue(opclass_e cls, alu_op_e op, logic [63:0] src1,
                                            logic [63:0] src2, logic [63:0] base,
                                            logic [63:0] imm);
    exu_issue_t iss;
    iss.opclass = cls;
    iss.alu_op  = op;
    iss.rd      = rand_rd();
    iss.src1    = src1;
    iss.src2    = src2;
    iss.base    = base;
    iss.imm.imm = imm;
    iss.pc      = '0;
    return iss;
  endfunction

  function automatic exu_issue_t make_sys(sys_f3_e f3, logic [11:0] num, logic [63:0] src1);
    sys_imm_u u;
    u.sys.pad         = '0;
    u.sys.csr_or_priv = num;
    u.sys.funct3      = f3;
    return make_issue(op_system, alu_add, src1, rand64(), rand64(), u.imm);
  endfunction

  // runs the model one step and stores the entry
  task automatic add_entry(input string name, input exu_issue_t iss_in);
    exu_issue_t  iss;
    exu_result_t r;
    logic [63:0] addr;
    logic [63:0] old_csr;
    logic [63:0] wval;
    logic [11:0] num;
    sys_f3_e     f3;
    logic        priv;
    iss = iss_in;
    iss.pc = cur_pc;
    cur_pc = cur_pc + 64'd4;
    addr = iss.base + iss.imm.imm;
    num = iss.imm.sys.csr_or_priv;
    f3 = iss.imm.sys.funct3;
    priv = iss.opclass == op_system && f3 == sys_priv;
    r.pc = iss.pc;
    r.ebreak = priv && num == priv_ebreak;
    r.npc = addr;
    r.take_npc = 1'b0;
    r.rd = iss.rd;
    r.reg_wen = 1'b1;
    r.reg_wdata = alu_model(iss.alu_op, iss.src1, iss.src2);
    case (iss.opclass)
      op_branch: begin
        r.take_npc = branch_taken(iss.alu_op, iss.src1, iss.src2);
        r.rd = 5'd0;
        r.reg_wen = 1'b0;
      end
      op_jal, op_jalr: begin
        r.take_npc = 1'b1;
        r.reg_wdata = iss.pc + 64'd4;
      end
      op_store: begin
        mem_model[word_index(addr)] = iss.src2;
        r.rd = 5'd0;
        r.reg_wen = 1'b0;
      end
      op_load: r.reg_wdata = mem_model[word_index(addr)];
      op_system: begin
        old_csr = csr_read(num);
        r.reg_wdata = old_csr;
        if (priv) begin
          r.rd = 5'd0;
          r.reg_wen = 1'b0;
          if (num == priv_ecall) begin
            r.take_npc = 1'b1;
            r.npc = m_mtvec;
            m_mepc = iss.pc;
            m_mcause = 64'd11;
          end else if (num == priv_mret) begin
            r.take_npc = 1'b1;
            r.npc = m_mepc;
            m_mstatus[3] = m_mstatus[7];
            m_mstatus[7] = 1'b1;
          end
        end else begin
          case (f3)
            sys_csrrw, sys_csrrwi: wval = iss.src1;
            sys_csrrs, sys_csrrsi: wval = old_csr | iss.src1;
            sys_csrrc, sys_csrrci: wval = old_csr & ~iss.src1;
            default:               wval = old_csr;
          endcase
          csr_write(num, wval);
        end
      end
      default: r.reg_wen = 1'b1;
    endcase
    names.push_back(name);
    issues.push_back(iss);
    expected.push_back(r);
  endtask

  task automatic build_table();
    alu_op_e     op;
    alu_op_e     br_ops[6];
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] a;
    int          k;
    br_ops = '{alu_sub, alu_xor, alu_slt, alu_sltu, alu_sle, alu_sleu};
    for (k = 0; k < 24; k++) begin
      op = alu_op_e'(k % 12);
      add_entry($sformatf("alu_%s_%0d", op.name(), k / 12),
                make_issue(op_alu, op, rand64(), rand64(), rand64(), rand64()));
    end
    // equal, then both orders of an unequal pair
    for (k = 0; k < 6; k++) begin
      x = rand64();
      y = rand64();
      add_entry($sformatf("br_%s_eq", br_ops[k].name()),
                make_issue(op_branch, br_ops[k], x, x, rand64(), rand64()));
      add_entry($sformatf("br_%s_xy", br_ops[k].name()),
                make_issue(op_branch, br_ops[k], x, y, rand64(), rand64()));
      add_entry($sformatf("br_%s_yx", br_ops[k].name()),
                make_issue(op_branch, br_ops[k], y, x, rand64(), rand64()));
    end
    add_entry("jal", make_issue(op_jal, alu_add, 64'd0, 64'd0, cur_pc, 64'h200));
    add_entry("jalr", make_issue(op_jalr, alu_add, 64'd0, 64'd0, rand64(), 64'hffff_fff0));
    a = rand64();
    add_entry("store_a", make_issue(op_store, alu_add, rand64(), rand64(), a, 64'd0));
    add_entry("load_a", make_issue(op_load, alu_add, rand64(), rand64(), a - 64'h40, 64'h40));
    // second address is reached through the wrap of the array
    x = rand64();
    add_entry("store_b", make_issue(op_store, alu_add, rand64(), rand64(), x, -64'sd8));
    add_entry("load_b_alias", make_issue(op_load, alu_add, rand64(), rand64(),
                                         x + 64'(mem_words * 8), -64'sd8));
    y = rand64();
    add_entry("store_c1", make_issue(op_store, alu_add, rand64(), rand64(), y, 64'd0));
    add_entry("store_c2", make_issue(op_store, alu_sub, rand64(), rand64(), y, 64'd0));
    add_entry("load_c", make_issue(op_load, alu_add, rand64(), rand64(), y, 64'd0));
    add_entry("load_a_again", make_issue(op_load, alu_add, rand64(), rand64(), a, 64'd0));
    add_entry("csrrw_mtvec", make_sys(sys_csrrw, csr_mtvec, rand64()));
    add_entry("csrrs_mtvec", make_sys(sys_csrrs, csr_mtvec, rand64()));
    add_entry("csrrc_mtvec", make_sys(sys_csrrc, csr_mtvec, rand64()));
    add_entry("read_mtvec", make_sys(sys_csrrs, csr_mtvec, 64'd0));
    add_entry("csrrwi_mcause", make_sys(sys_csrrwi, csr_mcause, 64'd21));
    add_entry("csrrsi_mstatus", make_sys(sys_csrrsi, csr_mstatus, 64'd8));
    add_entry("csrrci_mstatus", make_sys(sys_csrrci, csr_mstatus, 64'd8));
    add_entry("csrrw_unknown", make_sys(sys_csrrw, 12'h340, rand64()));
    // trap entry and return
    add_entry("set_mtvec", make_sys(sys_csrrw, csr_mtvec, 64'h8000_0100));
    add_entry("ecall", make_sys(sys_priv, priv_ecall, rand64()));
    add_entry("read_mepc", make_sys(sys_csrrs, csr_mepc, 64'd0));
    add_entry("read_mcause", make_sys(sys_csrrs, csr_mcause, 64'd0));
    add_entry("set_mie", make_sys(sys_csrrsi, csr_mstatus, 64'd8));
    add_entry("mret", make_sys(sys_priv, priv_mret, rand64()));
    add_entry("read_mstatus", make_sys(sys_csrrs, csr_mstatus, 64'd0));
    add_entry("ebreak", make_sys(sys_priv, priv_ebreak, rand64()));
  endtask

  task automatic drive_table();
    int i;
    for (i = 0; i < issues.size(); i++) begin
      @(posedge clk);
      if (($random(seed) & 7) == 0) begin
        in_valid_i <= 1'b0;
        @(posedge clk);
      end
      in_valid_i <= 1'b1;
      in_issue_i <= issues[i];
      // transfer happens on the edge after a ready sample
      @(negedge clk);
      while (!in_ready_o) @(negedge clk);
    end
    @(posedge clk);
    in_valid_i <= 1'b0;
  endtask

  task automatic compare_field(input string test, input string field,
                               input logic [63:0] exp_v, input logic [63:0] act_v);
    assert (act_v === exp_v) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", test, field, exp_v, act_v);
      mismatch_cnt++;
    end
  endtask

  task automatic check_result(input int i);
    exu_result_t e;
    e = expected[i];
    compare_field(names[i], "pc", e.pc, out_result_o.pc);
    compare_field(names[i], "rd", 64'(e.rd), 64'(out_result_o.rd));
    compare_field(names[i], "reg_wen", 64'(e.reg_wen), 64'(out_result_o.reg_wen));
    compare_field(names[i], "reg_wdata", e.reg_wdata, out_result_o.reg_wdata);
    compare_field(names[i], "npc", e.npc, out_result_o.npc);
    compare_field(names[i], "take_npc", 64'(e.take_npc), 64'(out_result_o.take_npc));
    compare_field(names[i], "ebreak", 64'(e.ebreak), 64'(out_result_o.ebreak));
  endtask

  // random back-pressure stretches
  always @(posedge clk) begin
    if (stall_left > 0) begin
      stall_left <= stall_left - 1;
      out_ready_i <= 1'b0;
    end else if (($random(seed) & 3) == 0) begin
      stall_left <= $random(seed) & 7;
      out_ready_i <= 1'b0;
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  // a result leaves on the edge after this sample
  always @(negedge clk) begin
    if (!rst && out_valid_o && out_ready_i) begin
      assert (res_idx < expected.size()) else begin
        $display("extra result with pc %h after the last table entry", out_result_o.pc);
        other_cnt++;
      end
      if (res_idx < expected.size()) check_result(res_idx);
      res_idx++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, %0d of %0d results seen",
               cycles, res_idx, expected.size());
      other_cnt++;
      $display("result checks: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    in_valid_i = 1'b0;
    in_issue_i = '0;
    out_ready_i = 1'b0;
    build_table();
    limit = 40 * expected.size() + 100;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    drive_table();
    wait (res_idx >= expected.size());
    repeat (10) @(posedge clk);
    assert (res_idx == expected.size()) else begin
      $display("got %0d results for %0d table entries", res_idx, expected.size());
      other_cnt++;
    end
    $display("result checks: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verification/exu_asserts.sv */
`timescale 1ns/100ps

module exu_asserts import exu_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        in_ready_i,
  input logic        out_valid_i,
  input logic        out_ready_i,
  input exu_result_t out_result_i,
  input logic        mem_req_valid_i,
  input logic        mem_resp_valid_i
);

  // request sent, answer not yet back
  logic pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (mem_req_valid_i) begin
      pending <= 1'b1;
    end else if (mem_resp_valid_i) begin
      pending <= 1'b0;
    end
  end

  hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_result_i))
    else $error("result changed while held");

  single_request: assert property (@(posedge clk) disable iff (rst)
    pending |-> !mem_req_valid_i)
    else $error("memory request sent while an answer is outstanding");

  no_issue_while_held: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |-> !in_ready_i)
    else $error("core ready for issue while a result waits");

endmodule

bind exu_core exu_asserts asserts_i (
  .clk              (clk),
  .rst              (rst),
  .in_ready_i       (in_ready_o),
  .out_valid_i      (out_valid_o),
  .out_ready_i      (out_ready_i),
  .out_result_i     (out_result_o),
  .mem_req_valid_i  (mem_req_valid_o),
  .mem_resp_valid_i (mem_resp_valid_i)
);

/* src/exu_top.sv */
`timescale 1ns/100ps

module exu_top import exu_pkg::*; #(
  parameter int XLEN      = 64,
  parameter int MEM_WORDS = 256,
  parameter int MEM_DELAY = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  exu_issue_t  in_issue_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output exu_result_t out_result_o
);

  logic            mem_req_valid;
  mem_req_t        mem_req;
  logic            mem_resp_valid;
  logic [XLEN-1:0] mem_rdata;

  exu_core #(.XLEN(XLEN)) core_i (
    .clk              (clk),
    .rst              (rst),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .in_issue_i       (in_issue_i),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i),
    .out_result_o     (out_result_o),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_o        (mem_req),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_rdata_i      (mem_rdata)
  );

  exu_data_mem #(
    .XLEN      (XLEN),
    .MEM_WORDS (MEM_WORDS),
    .MEM_DELAY (MEM_DELAY)
  ) mem_i (
    .clk          (clk),
    .rst          (rst),
    .req_valid_i  (mem_req_valid),
    .req_i        (mem_req),
    .resp_valid_o (mem_resp_valid),
    .rdata_o      (mem_rdata)
  );

endmodule

/* src/exu_data_mem.sv */
`timescale 1ns/100ps

module exu_data_mem import exu_pkg::*; #(
  parameter int XLEN      = 64,
  parameter int MEM_WORDS = 256,
  parameter int MEM_DELAY = 2
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_valid_i,
  input  mem_req_t        req_i,
  output logic            resp_valid_o,
  output logic [XLEN-1:0] rdata_o
);

  localparam int aw    = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int cnt_w = $clog2(MEM_DELAY + 1);

  logic [XLEN-1:0]  mem [MEM_WORDS];
  logic [XLEN-1:0]  word_addr;
  logic [aw-1:0]    idx;
  logic [aw-1:0]    idx_q;
  logic             busy;
  logic [cnt_w-1:0] cnt;

  // byte address to word index, wrapped to the array depth
  assign word_addr = req_i.addr >> 3;
  assign idx       = aw'(word_addr % MEM_WORDS);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy         <= 1'b0;
      cnt          <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= 1'b0;
      if (req_valid_i) begin
        busy <= 1'b1;
        cnt  <= cnt_w'(MEM_DELAY);
      end else if (busy) begin
        if (cnt == cnt_w'(1)) begin
          busy         <= 1'b0;
          resp_valid_o <= 1'b1;
        end
        cnt <= cnt - 1'b1;
      end
    end
  end

  // stores land at request time
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      idx_q <= idx;
      if (req_i.we) mem[idx] <= req_i.wdata;
    end
    if (busy && !req_valid_i && cnt == cnt_w'(1)) begin
      rdata_o <= mem[idx_q];
    end
  end

endmodule

/* src/exu_core.sv */
`timescale 1ns/100ps

module exu_core import exu_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst,

  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  exu_issue_t      in_issue_i,

  output logic            out_valid_o,
  input  logic            out_ready_i,
  output exu_result_t     out_result_o,

  output logic            mem_req_valid_o,
  output mem_req_t        mem_req_o,
  input  logic            mem_resp_valid_i,
  input  logic [XLEN-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_mem_wait,
    st_hold
  } state_e;

  state_e          state;
  exu_issue_t      issue_q;
  logic [XLEN-1:0] rdata_q;
  logic            req_q;

  logic            accept;
  logic            commit;
  logic            in_is_mem;

  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] csr_wdata;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;

  logic            is_sys;
  logic            is_priv;
  logic            is_csr;
  logic            is_ecall;
  logic            is_mret;
  logic            is_ebreak;
  logic            branch_take;
  sys_f3_e         f3;
  logic [11:0]     sys_num;

  assign in_ready_o  = (state == st_idle) || (state == st_hold && out_ready_i);
  assign out_valid_o = state == st_hold;
  assign accept      = in_valid_i && in_ready_o;
  assign commit      = out_valid_o && out_ready_i;
  assign in_is_mem   = in_issue_i.opclass == op_load || in_issue_i.opclass == op_store;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      req_q <= 1'b0;
    end else begin
      req_q <= 1'b0;
      case (state)
        st_mem_wait: if (mem_resp_valid_i) state <= st_hold;
        st_hold:     if (out_ready_i) state <= st_idle;
        default:     state <= state;
      endcase
      // a new issue overrides the hold exit
      if (accept) begin
        if (in_is_mem) begin
          state <= st_mem_wait;
          req_q <= 1'b1;
        end else begin
          state <= st_hold;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) issue_q <= in_issue_i;
    if (state == st_mem_wait && mem_resp_valid_i) rdata_q <= mem_rdata_i;
  end

  // load/store address and jump target share one adder
  assign target = issue_q.base + issue_q.imm.imm;

  always_comb begin
    mem_req_o.addr  = target;
    mem_req_o.wdata = issue_q.src2;
    mem_req_o.we    = issue_q.opclass == op_store;
  end
  assign mem_req_valid_o = req_q;

  exu_alu #(.XLEN(XLEN)) alu_i (
    .alu_op_i (issue_q.alu_op),
    .src1_i   (issue_q.src1),
    .src2_i   (issue_q.src2),
    .result_o (alu_res)
  );

  // system decode via the union view
  assign f3        = issue_q.imm.sys.funct3;
  assign sys_num   = issue_q.imm.sys.csr_or_priv;
  assign is_sys    = issue_q.opclass == op_system;
  assign is_priv   = is_sys && f3 == sys_priv;
  assign is_csr    = is_sys && f3 != sys_priv;
  assign is_ecall  = is_priv && sys_num == priv_ecall;
  assign is_mret   = is_priv && sys_num == priv_mret;
  assign is_ebreak = is_priv && sys_num == priv_ebreak;

  always_comb begin
    case (f3)
      sys_csrrs, sys_csrrsi: csr_wdata = csr_rdata | issue_q.src1;
      sys_csrrc, sys_csrrci: csr_wdata = csr_rdata & ~issue_q.src1;
      default:               csr_wdata = issue_q.src1;
    endcase
  end

  exu_csr_file csr_i (
    .clk       (clk),
    .rst       (rst),
    .wen_i     (commit && is_csr),
    .waddr_i   (sys_num),
    .wdata_i   (csr_wdata),
    .raddr_i   (sys_num),
    .rdata_o   (csr_rdata),
    .trap_i    (commit && is_ecall),
    .trap_pc_i (issue_q.pc),
    .mret_i    (commit && is_mret),
    .mtvec_o   (mtvec),
    .mepc_o    (mepc)
  );

  always_comb begin
    case (issue_q.alu_op)
      alu_sub: branch_take = ~|alu_res;
      alu_xor, alu_slt, alu_sltu, alu_sle, alu_sleu: branch_take = |alu_res;
      default: branch_take = 1'b0;
    endcase
  end

  always_comb begin
    out_result_o.pc     = issue_q.pc;
    out_result_o.ebreak = is_ebreak;
    out_result_o.take_npc = issue_q.opclass == op_jal || issue_q.opclass == op_jalr ||
                            is_ecall || is_mret ||
                            (issue_q.opclass == op_branch && branch_take);
    if (is_ecall) out_result_o.npc = mtvec;
    else if (is_mret) out_result_o.npc = mepc;
    else out_result_o.npc = target;

    case (issue_q.opclass)
      op_load:         out_result_o.reg_wdata = rdata_q;
      op_jal, op_jalr: out_result_o.reg_wdata = issue_q.pc + XLEN'(4);
      op_system:       out_result_o.reg_wdata = csr_rdata;
      default:         out_result_o.reg_wdata = alu_res;
    endcase

    // no destination for stores, branches and priv ops
    if (issue_q.opclass == op_store || issue_q.opclass == op_branch || is_priv) begin
      out_result_o.rd      = 5'd0;
      out_result_o.reg_wen = 1'b0;
    end else begin
      out_result_o.rd      = issue_q.rd;
      out_result_o.reg_wen = 1'b1;
    end
  end

endmodule

/* src/exu_csr_file.sv */
`timescale 1ns/100ps

module exu_csr_file import exu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              wen_i,
  input  logic [11:0]       waddr_i,
  input  logic [data_w-1:0] wdata_i,
  input  logic [11:0]       raddr_i,
  output logic [data_w-1:0] rdata_o,
  input  logic              trap_i,
  input  logic [data_w-1:0] trap_pc_i,
  input  logic              mret_i,
  output logic [data_w-1:0] mtvec_o,
  output logic [data_w-1:0] mepc_o
);

  localparam int mie_bit  = 3;
  localparam int mpie_bit = 7;
  // environment call from M-mode
  localparam logic [data_w-1:0] cause_ecall_m = data_w'(11);

  logic [data_w-1:0] mstatus;
  logic [data_w-1:0] mtvec;
  logic [data_w-1:0] mepc;
  logic [data_w-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (wen_i) begin
        case (waddr_i)
          csr_mstatus: mstatus <= wdata_i;
          csr_mtvec:   mtvec   <= wdata_i;
          csr_mepc:    mepc    <= wdata_i;
          csr_mcause:  mcause  <= wdata_i;
          default:     mstatus <= mstatus;
        endcase
      end
      if (trap_i) begin
        mepc   <= trap_pc_i;
        mcause <= cause_ecall_m;
      end
      if (mret_i) begin
        mstatus[mie_bit]  <= mstatus[mpie_bit];
        mstatus[mpie_bit] <= 1'b1;
      end
    end
  end

  // unknown addresses read as zero
  always_comb begin
    case (raddr_i)
      csr_mstatus: rdata_o = mstatus;
      csr_mtvec:   rdata_o = mtvec;
      csr_mepc:    rdata_o = mepc;
      csr_mcause:  rdata_o = mcause;
      default:     rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

/* src/exu_alu.sv */
`timescale 1ns/100ps

module exu_alu import exu_pkg::*; #(
  parameter int XLEN = 64
) (
  input  alu_op_e           alu_op_i,
  input  logic [XLEN-1:0]   src1_i,
  input  logic [XLEN-1:0]   src2_i,
  output logic [XLEN-1:0]   result_o
);

  localparam int shw = $clog2(XLEN);

  logic [shw-1:0] shamt;
  logic           lt_s;
  logic           lt_u;
  logic           eq;

  assign shamt = src2_i[shw-1:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = src1_i == src2_i;

  always_comb begin
    case (alu_op_i)
      alu_add: result_o = src1_i + src2_i;
      alu_sub: result_o = src1_i - src2_i;
      alu_and: result_o = src1_i & src2_i;
      alu_or:  result_o = src1_i | src2_i;
      alu_xor: result_o = src1_i ^ src2_i;
      alu_sll: result_o = src1_i << shamt;
      alu_srl: result_o = src1_i >> shamt;
      alu_sra: result_o = $signed(src1_i) >>> shamt;
      // compares give 0 or 1
      alu_slt: begin
        result_o = {{(XLEN-1){1'b0}}, lt_s};
      end
      alu_sltu: begin
        result_o = {{(XLEN-1){1'b0}}, lt_u};
      end
      alu_sle: begin
        result_o = {{(XLEN-1){1'b0}}, lt_s | eq};
      end
      alu_sleu: begin
        result_o = {{(XLEN-1){1'b0}}, lt_u | eq};
      end
      default: result_o = '0;
    endcase
  end

endmodule

/* src/exu_pkg.sv */
package exu_pkg;

  // width of every data field in the structs below
  localparam int data_w = 64;

  typedef enum logic [2:0] {
    op_alu    = 3'd0,
    op_branch = 3'd1,
    op_jal    = 3'd2,
    op_jalr   = 3'd3,
    op_load   = 3'd4,
    op_store  = 3'd5,
    op_system = 3'd6
  } opclass_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_sle  = 4'd10,
    alu_sleu = 4'd11
  } alu_op_e;

  // funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    sys_priv   = 3'b000,
    sys_csrrw  = 3'b001,
    sys_csrrs  = 3'b010,
    sys_csrrc  = 3'b011,
    sys_csrrwi = 3'b101,
    sys_csrrsi = 3'b110,
    sys_csrrci = 3'b111
  } sys_f3_e;

  localparam logic [11:0] priv_ecall  = 12'h000;
  localparam logic [11:0] priv_ebreak = 12'h001;
  localparam logic [11:0] priv_mret   = 12'h302;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  typedef struct packed {
    logic [48:0] pad;
    logic [11:0] csr_or_priv;
    sys_f3_e     funct3;
  } sys_field_t;

  // same word, read as offset or as system fields
  typedef union packed {
    logic signed [data_w-1:0] imm;
    sys_field_t               sys;
  } sys_imm_u;

  typedef struct packed {
    opclass_e          opclass;
    alu_op_e           alu_op;
    logic [4:0]        rd;
    logic [data_w-1:0] src1;
    logic [data_w-1:0] src2;
    logic [data_w-1:0] base;
    sys_imm_u          imm;
    logic [data_w-1:0] pc;
  } exu_issue_t;

  typedef struct packed {
    logic [4:0]        rd;
    logic              reg_wen;
    logic [data_w-1:0] reg_wdata;
    logic [data_w-1:0] npc;
    logic              take_npc;
    logic              ebreak;
    logic [data_w-1:0] pc;
  } exu_result_t;

  typedef struct packed {
    logic [data_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic              we;
  } mem_req_t;

endpackage
